// ==== rtl/videoPkg.sv ====
package videoPkg;

   typedef logic [1:0] colorIndex_t;
   typedef logic [1:0] shade_t;
   typedef logic [7:0] tileIndex_t;
   typedef logic [7:0] lineNum_t;
   typedef logic [7:0] pixelX_t;

   // byte offset into video memory, 0 is 8000
   typedef logic [12:0] vramAddr_t;

   typedef struct packed {
      logic       lcdEnable;
      logic [1:0] reservedHigh;
      logic       tileDataUnsigned;
      logic       mapSelect;
      logic [2:0] reservedLow;
   } lcdControl_t;

   typedef struct packed {
      lineNum_t scrollY;
      pixelX_t  scrollX;
   } scroll_t;

   typedef struct packed {
      lcdControl_t control;
      scroll_t     scroll;
      logic [7:0]  bgPalette;
   } renderRegs_t;

   typedef struct packed {
      vramAddr_t addr;
      logic      read;
   } vramReadReq_t;

   typedef struct packed {
      logic     valid;
      shade_t   shade;
      pixelX_t  x;
      lineNum_t line;
   } pixelOut_t;

   typedef enum logic [2:0] {IDLE, FETCH_MAP, FETCH_LOW, FETCH_HIGH, PUSH} renderState_e;

endpackage

// ==== rtl/busPkg.sv ====
package busPkg;

   typedef logic [15:0] busAddr_t;
   typedef logic [7:0]  busData_t;

   typedef struct packed {
      busAddr_t addr;
      busData_t writeData;
      logic     read;
      logic     write;
   } busRequest_t;

   typedef struct packed {
      logic     valid;
      busData_t data;
   } busResponse_t;

   localparam busAddr_t LCDC_ADDR = 16'hff40;
   localparam busAddr_t SCY_ADDR  = 16'hff42;
   localparam busAddr_t SCX_ADDR  = 16'hff43;
   localparam busAddr_t BGP_ADDR  = 16'hff47;

   // 384 tiles of 16 bytes, then the two 32x32 maps
   localparam busAddr_t TILE_BASE  = 16'h8000;
   localparam busAddr_t TILE_BYTES = 16'h1800;
   localparam busAddr_t MAP0_BASE  = 16'h9800;
   localparam busAddr_t MAP1_BASE  = 16'h9c00;
   localparam busAddr_t MAP_BYTES  = 16'h0400;

endpackage

// ==== rtl/lcdRegisterFile.sv ====
`timescale 1ns/1ns

module lcdRegisterFile (
   input  logic                  cntrl,
   input  logic                  rst,
   input  busPkg::busRequest_t   bus,
   input  busPkg::busResponse_t  memResp,
   output busPkg::busResponse_t  busResp,
   output videoPkg::renderRegs_t renderRegs
);
   import videoPkg::*;
   import busPkg::*;

   localparam busData_t lcdcReset = 8'h90;
   // identity palette, index i maps to shade i
   localparam busData_t bgpReset  = 8'he4;

   lcdControl_t lcdc;
   scroll_t     scroll;
   busData_t    bgp;

   logic        regHit;
   busData_t    regData;
   logic        respValid;
   busData_t    respData;

   always_comb begin
      regHit  = 1'b1;
      regData = '0;
      case (bus.addr)
         LCDC_ADDR: regData = lcdc;
         SCY_ADDR:  regData = scroll.scrollY;
         SCX_ADDR:  regData = scroll.scrollX;
         BGP_ADDR:  regData = bgp;
         default:   regHit = 1'b0;
      endcase
   end

   always_ff @(posedge cntrl) begin
      if (rst) begin
         lcdc      <= lcdControl_t'(lcdcReset);
         scroll    <= '0;
         bgp       <= bgpReset;
         respValid <= 1'b0;
      end else begin
         respValid <= bus.read && regHit;
         if (bus.write) begin
            case (bus.addr)
               LCDC_ADDR: lcdc <= lcdControl_t'(bus.writeData);
               SCY_ADDR:  scroll.scrollY <= bus.writeData;
               SCX_ADDR:  scroll.scrollX <= bus.writeData;
               BGP_ADDR:  bgp <= bus.writeData;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge cntrl) begin
      if (bus.read) begin
         respData <= regData;
      end
   end

   // ranges are disjoint, at most one side answers
   always_comb begin
      busResp.valid = respValid | memResp.valid;
      busResp.data  = respValid ? respData : memResp.data;
   end

   assign renderRegs.control   = lcdc;
   assign renderRegs.scroll    = scroll;
   assign renderRegs.bgPalette = bgp;

endmodule

// ==== rtl/videoMemory.sv ====
`timescale 1ns/1ns

module videoMemory (
   input  logic                   cntrl,
   input  busPkg::busRequest_t    bus,
   output busPkg::busResponse_t   memResp,
   input  videoPkg::vramReadReq_t vramRead,
   output busPkg::busData_t       renderData
);
   import videoPkg::*;
   import busPkg::*;

   // tile data and both maps sit back to back from 8000
   localparam busAddr_t memSpan  = TILE_BYTES + 2 * MAP_BYTES;
   localparam int       memBytes = int'(memSpan);

   busData_t  mem [memBytes];

   logic      busHit;
   busAddr_t  busOffset;
   vramAddr_t cpuAddr;

   assign busHit    = (bus.addr >= TILE_BASE) && (bus.addr < TILE_BASE + memSpan);
   assign busOffset = bus.addr - TILE_BASE;
   assign cpuAddr   = busOffset[12:0];

   // cpu port
   always_ff @(posedge cntrl) begin
      if (bus.write && busHit) begin
         mem[cpuAddr] <= bus.writeData;
      end
   end

   always_ff @(posedge cntrl) begin
      memResp.valid <= bus.read && busHit;
      if (bus.read && busHit) begin
         memResp.data <= mem[cpuAddr];
      end
   end

   // render port, output holds until the next strobe
   always_ff @(posedge cntrl) begin
      if (vramRead.read) begin
         renderData <= mem[vramRead.addr];
      end
   end

endmodule

// ==== rtl/lineRenderer.sv ====
`timescale 1ns/1ns

module lineRenderer #(
   parameter int lineWidth = 160,
   parameter int numLines  = 144
) (
   input  logic                   cntrl,
   input  logic                   rst,
   input  logic                   drawLine,
   input  videoPkg::renderRegs_t  renderRegs,
   output videoPkg::vramReadReq_t vramRead,
   input  busPkg::busData_t       renderData,
   output videoPkg::pixelOut_t    pixel,
   output logic                   lineDone,
   output logic                   frameDone
);
   import videoPkg::*;
   import busPkg::*;

   localparam pixelX_t   lastX          = pixelX_t'(lineWidth - 1);
   localparam lineNum_t  lastLine       = lineNum_t'(numLines - 1);
   localparam vramAddr_t map0Offset     = vramAddr_t'(MAP0_BASE - TILE_BASE);
   localparam vramAddr_t map1Offset     = vramAddr_t'(MAP1_BASE - TILE_BASE);
   localparam vramAddr_t signedTileBase = 13'h1000;

   renderState_e state;
   renderRegs_t  latched;
   lineNum_t     line;
   lineNum_t     bgRow;
   pixelX_t      x;
   logic [4:0]   tileCol;
   logic [2:0]   bitIdx;
   busData_t     lowByte;
   vramAddr_t    rowAddr;
   vramAddr_t    mapAddr;
   vramAddr_t    tileAddr;
   vramAddr_t    lowAddr;
   colorIndex_t  colorIdx;
   shade_t       curShade;
   logic         lineEnd;
   logic         frameEnd;

   assign mapAddr = (latched.control.mapSelect ? map1Offset : map0Offset)
                    + vramAddr_t'({bgRow[7:3], tileCol});

   // in FETCH_LOW renderData is the map entry
   assign tileAddr = latched.control.tileDataUnsigned ?
                     vramAddr_t'({renderData, 4'b0000}) :
                     signedTileBase + {renderData[7], renderData, 4'b0000};
   assign lowAddr  = {tileAddr[12:4], bgRow[2:0], 1'b0};

   // in PUSH renderData still holds the high plane byte
   assign colorIdx = {renderData[3'd7 - bitIdx], lowByte[3'd7 - bitIdx]};
   assign curShade = latched.bgPalette[{colorIdx, 1'b0} +: 2];

   always_comb begin
      vramRead.read = 1'b0;
      vramRead.addr = mapAddr;
      case (state)
         FETCH_MAP: vramRead.read = 1'b1;
         FETCH_LOW: begin
            vramRead.read = 1'b1;
            vramRead.addr = lowAddr;
         end
         FETCH_HIGH: begin
            vramRead.read = 1'b1;
            vramRead.addr = {rowAddr[12:1], 1'b1};
         end
         default: ;
      endcase
   end

   always_ff @(posedge cntrl) begin
      if (rst) begin
         state     <= IDLE;
         line      <= '0;
         pixel     <= '0;
         lineEnd   <= 1'b0;
         frameEnd  <= 1'b0;
         lineDone  <= 1'b0;
         frameDone <= 1'b0;
      end else begin
         pixel.valid <= 1'b0;
         lineEnd     <= 1'b0;
         frameEnd    <= 1'b0;
         // done pulses trail the last pixel by one cycle
         lineDone    <= lineEnd;
         frameDone   <= frameEnd;
         case (state)
            IDLE: begin
               if (drawLine && renderRegs.control.lcdEnable) begin
                  latched <= renderRegs;
                  bgRow   <= line + renderRegs.scroll.scrollY;
                  tileCol <= renderRegs.scroll.scrollX[7:3];
                  bitIdx  <= renderRegs.scroll.scrollX[2:0];
                  x       <= '0;
                  state   <= FETCH_MAP;
               end
            end
            FETCH_MAP: state <= FETCH_LOW;
            FETCH_LOW: begin
               rowAddr <= lowAddr;
               state   <= FETCH_HIGH;
            end
            FETCH_HIGH: begin
               lowByte <= renderData;
               state   <= PUSH;
            end
            PUSH: begin
               pixel.valid <= 1'b1;
               pixel.shade <= curShade;
               pixel.x     <= x;
               pixel.line  <= line;
               x           <= x + 1'b1;
               bitIdx      <= bitIdx + 1'b1;
               if (x == lastX) begin
                  state    <= IDLE;
                  lineEnd  <= 1'b1;
                  frameEnd <= (line == lastLine);
                  line     <= (line == lastLine) ? '0 : line + 1'b1;
               end else if (bitIdx == 3'd7) begin
                  // map column wraps at 32 tiles
                  tileCol <= tileCol + 1'b1;
                  state   <= FETCH_MAP;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== rtl/whizGraphics.sv ====
`timescale 1ns/1ns

module whizGraphics #(
   parameter int lineWidth = 160,
   parameter int numLines  = 144
) (
   input  logic                 cntrl,
   input  logic                 rst,
   input  busPkg::busRequest_t  bus,
   input  logic                 drawLine,
   output busPkg::busResponse_t busResp,
   output videoPkg::pixelOut_t  pixel,
   output logic                 lineDone,
   output logic                 frameDone
);
   import videoPkg::*;
   import busPkg::*;

   busResponse_t memResp;
   renderRegs_t  renderRegs;
   vramReadReq_t vramRead;
   busData_t     renderData;

   lcdRegisterFile regs (
      .cntrl      (cntrl),
      .rst        (rst),
      .bus        (bus),
      .memResp    (memResp),
      .busResp    (busResp),
      .renderRegs (renderRegs)
   );

   videoMemory vram (
      .cntrl      (cntrl),
      .bus        (bus),
      .memResp    (memResp),
      .vramRead   (vramRead),
      .renderData (renderData)
   );

   lineRenderer #(
      .lineWidth (lineWidth),
      .numLines  (numLines)
   ) renderer (
      .cntrl      (cntrl),
      .rst        (rst),
      .drawLine   (drawLine),
      .renderRegs (renderRegs),
      .vramRead   (vramRead),
      .renderData (renderData),
      .pixel      (pixel),
      .lineDone   (lineDone),
      .frameDone  (frameDone)
   );

endmodule

// ==== tests/whizGraphics_asserts.sv ====
`timescale 1ns/1ns

module whizGraphicsAsserts (
   input logic cntrl,
   input logic rst,
   input logic mappedRead,
   input logic respValid,
   input logic pixelValid,
   input logic lineDone,
   input logic frameDone
);

   // registered response, one cycle behind the strobe
   assert property (@(posedge cntrl) disable iff (rst) mappedRead |=> respValid)
      else $error("no bus response in the cycle after a mapped read");
   assert property (@(posedge cntrl) disable iff (rst) !mappedRead |=> !respValid)
      else $error("bus response without a mapped read in the cycle before");

   assert property (@(posedge cntrl) disable iff (rst) !(pixelValid && lineDone))
      else $error("pixel valid and lineDone high in the same cycle");
   assert property (@(posedge cntrl) disable iff (rst) frameDone |-> lineDone)
      else $error("frameDone high without lineDone");

   assert property (@(posedge cntrl) rst |=> !(respValid || pixelValid || lineDone || frameDone))
      else $error("outputs not low in the cycle after reset");

endmodule

// 8000-9fff is video memory, the rest is decoded by regHit
bind lcdRegisterFile whizGraphicsAsserts busChecks (
   .cntrl      (cntrl),
   .rst        (rst),
   .mappedRead (bus.read && (regHit || bus.addr[15:13] == 3'b100)),
   .respValid  (busResp.valid),
   .pixelValid (1'b0),
   .lineDone   (1'b0),
   .frameDone  (1'b0)
);

bind lineRenderer whizGraphicsAsserts renderChecks (
   .cntrl      (cntrl),
   .rst        (rst),
   .mappedRead (1'b0),
   .respValid  (1'b0),
   .pixelValid (pixel.valid),
   .lineDone   (lineDone),
   .frameDone  (frameDone)
);

// ==== tests/whizGraphicsTb.sv ====
`timescale 1ns/1ns

module whizGraphicsTb;
   import videoPkg::*;
   import busPkg::*;

   localparam int numLines  = 4;
   localparam int lineWidth = 160;

   logic         cntrl;
   logic         rst;
   busRequest_t  bus;
   logic         drawLine;
   busResponse_t busResp;
   pixelOut_t    pixel;
   logic         lineDone;
   logic         frameDone;

   logic [31:0]  lfsr = 32'h38a4d187;
   // expected contents of video memory, offset 0 is 8000
   busData_t     model [8192];
   busData_t     lcdcModel = 8'h90;
   busData_t     scyModel  = 8'h00;
   busData_t     scxModel  = 8'h00;
   busData_t     bgpModel  = 8'he4;
   int           errors    = 0;
   int           testErrors;
   int           testsRun  = 0;
   int           nextLine  = 0;
   string        testName;

   whizGraphics #(.numLines(numLines)) dut (
      .cntrl     (cntrl),
      .rst       (rst),
      .bus       (bus),
      .drawLine  (drawLine),
      .busResp   (busResp),
      .pixel     (pixel),
      .lineDone  (lineDone),
      .frameDone (frameDone)
   );

   always #4 cntrl = ~cntrl;

   // galois lfsr, one step per bit
   function automatic busData_t randomByte();
      busData_t value;
      for (int i = 0; i < 8; i++) begin
         value = {value[6:0], lfsr[0]};
         lfsr  = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
      end
      return value;
   endfunction

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error %s: %s expected %0h actual %0h", testName, what, expected, actual);
         errors++;
      end
   endtask

   task automatic reportFailure(input string what);
      $display("%s: %s", testName, what);
      errors++;
   endtask

   task automatic startTest(input string name);
      testName   = name;
      testErrors = errors;
      testsRun++;
   endtask

   task automatic endTest();
      if (errors == testErrors)
         $display("%s: ok", testName);
      else
         $display("%s: %0d errors", testName, errors - testErrors);
   endtask

   task automatic busWrite(input busAddr_t addr, input busData_t data);
      bus.addr      = addr;
      bus.writeData = data;
      bus.write     = 1'b1;
      @(posedge cntrl);
      #1;
      bus.write = 1'b0;
      if (addr >= TILE_BASE && addr < 16'ha000)
         model[addr - TILE_BASE] = data;
      case (addr)
         LCDC_ADDR: lcdcModel = data;
         SCY_ADDR:  scyModel = data;
         SCX_ADDR:  scxModel = data;
         BGP_ADDR:  bgpModel = data;
         default: ;
      endcase
   endtask

   task automatic busRead(input busAddr_t addr, output logic valid, output busData_t data,
                          output int cycles);
      bus.addr = addr;
      bus.read = 1'b1;
      @(posedge cntrl);
      #1;
      bus.read = 1'b0;
      cycles = 1;
      while (!busResp.valid && cycles < 4) begin
         @(posedge cntrl);
         #1;
         cycles++;
      end
      valid = busResp.valid;
      data  = busResp.data;
   endtask

   task automatic readExpect(input busAddr_t addr, input busData_t expected);
      logic     valid;
      busData_t data;
      int       cycles;
      busRead(addr, valid, data, cycles);
      if (!valid) begin
         reportFailure($sformatf("no bus response for read of %h", addr));
      end else begin
         checkValue($sformatf("latency of read %h", addr), 1, cycles);
         checkValue($sformatf("read %h", addr), expected, data);
      end
   endtask

   function automatic shade_t expectedShade(input int line, input int x);
      int          row;
      int          col;
      int          mapBase;
      int          entry;
      int          tileBase;
      int          bitPos;
      colorIndex_t color;
      row     = (line + scyModel) % 256;
      col     = (x + scxModel) % 256;
      mapBase = lcdcModel[3] ? 'h1c00 : 'h1800;
      entry   = model[mapBase + (row / 8) * 32 + col / 8];
      if (lcdcModel[4]) begin
         tileBase = entry * 16;
      end else begin
         // signed mode, index 0 sits at 9000
         if (entry > 127)
            entry = entry - 256;
         tileBase = 'h1000 + entry * 16;
      end
      bitPos = 7 - col % 8;
      color  = {model[tileBase + (row % 8) * 2 + 1][bitPos],
                model[tileBase + (row % 8) * 2][bitPos]};
      return bgpModel[2 * color +: 2];
   endfunction

   task automatic renderLine();
      int count;
      int cycles;
      drawLine = 1'b1;
      @(posedge cntrl);
      #1;
      drawLine = 1'b0;
      count  = 0;
      cycles = 0;
      while (!lineDone && cycles < 1000) begin
         if (pixel.valid) begin
            checkValue("pixel x", count, pixel.x);
            checkValue("pixel line", nextLine, pixel.line);
            checkValue($sformatf("shade at line %0d x %0d", nextLine, count),
                       expectedShade(nextLine, count), pixel.shade);
            count++;
         end
         @(posedge cntrl);
         #1;
         cycles++;
      end
      if (!lineDone) begin
         reportFailure($sformatf("line %0d did not finish", nextLine));
      end else begin
         checkValue("pixel count", lineWidth, count);
         checkValue($sformatf("frameDone on line %0d", nextLine),
                    nextLine == numLines - 1, frameDone);
      end
      nextLine = (nextLine + 1) % numLines;
   endtask

   task automatic testRegisters();
      startTest("registers");
      readExpect(LCDC_ADDR, 8'h90);
      readExpect(BGP_ADDR, 8'he4);
      readExpect(SCX_ADDR, 8'h00);
      readExpect(SCY_ADDR, 8'h00);
      busWrite(SCX_ADDR, 8'h5a);
      busWrite(SCY_ADDR, 8'ha5);
      busWrite(BGP_ADDR, 8'h1b);
      busWrite(LCDC_ADDR, 8'h91);
      readExpect(SCX_ADDR, 8'h5a);
      readExpect(SCY_ADDR, 8'ha5);
      readExpect(BGP_ADDR, 8'h1b);
      readExpect(LCDC_ADDR, 8'h91);
      endTest();
   endtask

   task automatic testMemory();
      busData_t hi;
      busData_t lo;
      busData_t data;
      busAddr_t addr;
      logic     valid;
      int       cycles;
      startTest("memory");
      for (int i = 0; i < 32; i++) begin
         hi   = randomByte();
         lo   = randomByte();
         data = randomByte();
         addr = TILE_BASE + {hi[4:0], lo};
         busWrite(addr, data);
         readExpect(addr, data);
      end
      busRead(16'hff44, valid, data, cycles);
      checkValue("valid for unmapped ff44", 0, valid);
      endTest();
   endtask

   task automatic testLineRender();
      startTest("line render");
      for (int i = 0; i < 8192; i++)
         busWrite(TILE_BASE + i, randomByte());
      busWrite(SCX_ADDR, randomByte() | 8'h03);
      busWrite(SCY_ADDR, randomByte() | 8'h01);
      busWrite(BGP_ADDR, 8'h1b);
      busWrite(LCDC_ADDR, 8'h90);
      renderLine();
      renderLine();
      endTest();
   endtask

   task automatic testAddressModes();
      startTest("addressing modes");
      // map 1 unsigned, map 1 signed, map 0 signed
      busWrite(LCDC_ADDR, 8'h98);
      renderLine();
      busWrite(LCDC_ADDR, 8'h88);
      renderLine();
      busWrite(LCDC_ADDR, 8'h80);
      renderLine();
      endTest();
   endtask

   task automatic testFrameAndEnable();
      int count;
      startTest("frame and enable");
      busWrite(LCDC_ADDR, 8'h90);
      // five lines always cross one frame boundary
      for (int i = 0; i < 5; i++)
         renderLine();
      busWrite(LCDC_ADDR, 8'h10);
      drawLine = 1'b1;
      @(posedge cntrl);
      #1;
      drawLine = 1'b0;
      count = 0;
      for (int i = 0; i < 50; i++) begin
         if (pixel.valid || lineDone)
            count++;
         @(posedge cntrl);
         #1;
      end
      checkValue("outputs with LCD disabled", 0, count);
      busWrite(LCDC_ADDR, 8'h90);
      endTest();
   endtask

   initial begin
      cntrl    = 1'b0;
      rst      = 1'b1;
      bus      = '0;
      drawLine = 1'b0;
      repeat (16) @(posedge cntrl);
      #1;
      rst = 1'b0;
      testRegisters();
      testMemory();
      testLineRender();
      testAddressModes();
      testFrameAndEnable();
      $display("tests run %0d, errors %0d", testsRun, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
rtl/videoPkg.sv
rtl/busPkg.sv
rtl/lcdRegisterFile.sv
rtl/videoMemory.sv
rtl/lineRenderer.sv
rtl/whizGraphics.sv
tests/whizGraphics_asserts.sv
tests/whizGraphicsTb.sv
